//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_exec_stage
FILELIST = exec_stage.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/exec_stage_properties.sv
module exec_stage_properties (
    input logic                   clk_i,
    input logic                   rstn_i,
    input logic                   flush_o,
    input rv_exec_pkg::exec_out_t out_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // a flush out of reset turns into a registered jump
    flush_then_jump: assert property (
        @(posedge clk_i) (rstn_i && flush_o) |=> out_o.jump
    ) else $error("flush_o was not followed by out_o.jump");

    reset_clears_out: assert property (
        @(posedge clk_i) !rstn_i |=> (!out_o.reg_write && !out_o.jump)
    ) else $error("out_o.reg_write or out_o.jump set after a reset edge");

    // only control transfers may jump
    jump_opcode: assert property (
        @(posedge clk_i) out_o.jump |-> (out_o.instr[6:0] == rv_exec_pkg::OPC_JAL
                                      || out_o.instr[6:0] == rv_exec_pkg::OPC_JALR
                                      || out_o.instr[6:0] == rv_exec_pkg::OPC_BRANCH)
    ) else $error("out_o.jump set for an opcode that is not a jump or branch");

endmodule

bind exec_stage exec_stage_properties u_properties (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .flush_o (flush_o),
    .out_o   (out_o)
);

//--- dv/tb_exec_stage.sv
module tb_exec_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 4;
    localparam logic [31:0] PC0        = 32'h0000_1000;

    localparam rv_exec_pkg::fwd_t NOF = '0;    // no forwarding

    typedef struct packed {
        logic [31:0]       instr;
        logic [31:0]       pc;
        logic [31:0]       rs1;
        logic [31:0]       rs2;
        rv_exec_pkg::fwd_t fwd;
        logic [2:0]        exp_ctl;            // flush, reg_write, jump
        logic [31:0]       exp_result;
    } row_t;

    logic                   clk_i;
    logic                   rstn_i;
    rv_exec_pkg::word_t     instr_i;
    rv_exec_pkg::word_t     pc_i;
    rv_exec_pkg::word_t     rs1_i;
    rv_exec_pkg::word_t     rs2_i;
    rv_exec_pkg::fwd_t      fwd_i;
    logic                   flush_o;
    rv_exec_pkg::exec_out_t out_o;

    row_t  rows[$];
    string names[$];
    int    checks;
    int    errors;
    bit    table_ready;

    exec_stage u_exec_stage (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .instr_i (instr_i),
        .pc_i    (pc_i),
        .rs1_i   (rs1_i),
        .rs2_i   (rs2_i),
        .fwd_i   (fwd_i),
        .flush_o (flush_o),
        .out_o   (out_o)
    );

    // encoders use rd x1, rs1 x2 and rs2 x3
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd3, 5'd2, f3, 5'd1, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd2, f3, 5'd1, 7'b0010011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd3, 5'd2, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic rv_exec_pkg::fwd_t forward_sel(input logic s1, input logic s2,
                                                      input logic [31:0] d1,
                                                      input logic [31:0] d2);
        return {s1, s2, d1, d2};
    endfunction

    task automatic add_row(input string name, input logic [31:0] instr, input logic [31:0] pc,
                           input logic [31:0] rs1, input logic [31:0] rs2,
                           input rv_exec_pkg::fwd_t fwd, input logic [2:0] ctl,
                           input logic [31:0] result);
        row_t r;
        r.instr      = instr;
        r.pc         = pc;
        r.rs1        = rs1;
        r.rs2        = rs2;
        r.fwd        = fwd;
        r.exp_ctl    = ctl;
        r.exp_result = result;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [98:0] exp, input logic [98:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %0h, actual %0h", name, what, exp, act);
        end
    endtask

    task automatic build_table();
        add_row("add", r_type(7'h00, 3'h0), PC0, 32'd5, 32'd7, NOF, 3'b010, 32'd12);
        add_row("sub_under", r_type(7'h20, 3'h0), PC0, 32'd3, 32'd5, NOF, 3'b010, 32'hFFFFFFFE);
        add_row("sll", r_type(7'h00, 3'h1), PC0, 32'd1, 32'h24, NOF, 3'b010, 32'h10);
        add_row("slt", r_type(7'h00, 3'h2), PC0, '1, 32'd1, NOF, 3'b010, 32'd1);
        add_row("sltu", r_type(7'h00, 3'h3), PC0, '1, 32'd1, NOF, 3'b010, 32'd0);
        add_row("xor", r_type(7'h00, 3'h4), PC0, 32'hF0F0F0F0, 32'h0FF00FF0, NOF, 3'b010,
                32'hFF00FF00);
        add_row("or", r_type(7'h00, 3'h6), PC0, 32'hFF00FF00, 32'h0FF00FF0, NOF, 3'b010,
                32'hFFF0FFF0);
        add_row("srl", r_type(7'h00, 3'h5), PC0, 32'h80000000, 32'd4, NOF, 3'b010, 32'h08000000);
        add_row("sra_neg", r_type(7'h20, 3'h5), PC0, 32'h80000000, 32'd4, NOF, 3'b010,
                32'hF8000000);
        add_row("and", r_type(7'h00, 3'h7), PC0, 32'hFFFF0000, 32'h12345678, NOF, 3'b010,
                32'h12340000);
        add_row("addi", i_type(12'hFFD, 3'h0), PC0, 32'd10, '0, NOF, 3'b010, 32'd7);
        add_row("slti_neg", i_type(12'hFFF, 3'h2), PC0, 32'hFFFFFFF0, '0, NOF, 3'b010, 32'd1);
        add_row("sltiu", i_type(12'hFFF, 3'h3), PC0, 32'd5, '0, NOF, 3'b010, 32'd1);
        add_row("xori", i_type(12'hFFF, 3'h4), PC0, 32'hFF, '0, NOF, 3'b010, 32'hFFFFFF00);
        add_row("ori", i_type(12'h0F0, 3'h6), PC0, 32'h10000000, '0, NOF, 3'b010, 32'h100000F0);
        add_row("andi", i_type(12'h0FF, 3'h7), PC0, 32'h12345678, '0, NOF, 3'b010, 32'h78);
        add_row("slli_31", i_type(12'h01F, 3'h1), PC0, 32'd1, '0, NOF, 3'b010, 32'h80000000);
        add_row("srli_31", i_type(12'h01F, 3'h5), PC0, 32'h80000000, '0, NOF, 3'b010, 32'd1);
        add_row("srai_31", i_type(12'h41F, 3'h5), PC0, 32'h80000000, '0, NOF, 3'b010, '1);
        add_row("clz_zero", i_type(12'h600, 3'h1), PC0, '0, '0, NOF, 3'b010, 32'd32);
        add_row("ctz_zero", i_type(12'h601, 3'h1), PC0, '0, '0, NOF, 3'b010, 32'd32);
        add_row("clz_ones", i_type(12'h600, 3'h1), PC0, '1, '0, NOF, 3'b010, 32'd0);
        add_row("ctz_ones", i_type(12'h601, 3'h1), PC0, '1, '0, NOF, 3'b010, 32'd0);
        add_row("cpop_ones", i_type(12'h602, 3'h1), PC0, '1, '0, NOF, 3'b010, 32'd32);
        add_row("clz_bit16", i_type(12'h600, 3'h1), PC0, 32'h00010000, '0, NOF, 3'b010, 32'd15);
        add_row("ctz_bit16", i_type(12'h601, 3'h1), PC0, 32'h00010000, '0, NOF, 3'b010, 32'd16);
        add_row("cpop_mix", i_type(12'h602, 3'h1), PC0, 32'hF0F00001, '0, NOF, 3'b010, 32'd9);
        // a taken branch targets pc plus the B immediate
        add_row("beq_t", b_type(13'd16, 3'h0), PC0, 32'h55, 32'h55, NOF, 3'b101, 32'h1010);
        add_row("beq_n", b_type(13'd16, 3'h0), PC0, 32'd1, 32'd2, NOF, 3'b000, 32'd0);
        add_row("bne_t", b_type(13'h1FF8, 3'h1), PC0, 32'd1, 32'd2, NOF, 3'b101, 32'h0FF8);
        add_row("bne_n", b_type(13'h1FF8, 3'h1), PC0, 32'd7, 32'd7, NOF, 3'b000, 32'd0);
        add_row("blt_t", b_type(13'd16, 3'h4), PC0, 32'h80000000, 32'h7FFFFFFF, NOF, 3'b101,
                32'h1010);
        add_row("blt_n", b_type(13'd16, 3'h4), PC0, 32'h7FFFFFFF, 32'h80000000, NOF, 3'b000,
                32'd0);
        add_row("bge_t", b_type(13'h1000, 3'h5), 32'h2000, '1, '1, NOF, 3'b101, 32'h1000);
        add_row("bge_n", b_type(13'h1000, 3'h5), 32'h2000, '1, '0, NOF, 3'b000, 32'd0);
        add_row("bltu_t", b_type(13'h0FFE, 3'h6), PC0, '0, '1, NOF, 3'b101, 32'h1FFE);
        add_row("bltu_n", b_type(13'h0FFE, 3'h6), PC0, '1, '0, NOF, 3'b000, 32'd0);
        add_row("bgeu_t", b_type(13'd16, 3'h7), PC0, 32'h80000000, 32'h7FFFFFFF, NOF, 3'b101,
                32'h1010);
        add_row("bgeu_n", b_type(13'd16, 3'h7), PC0, 32'h7FFFFFFF, 32'h80000000, NOF, 3'b000,
                32'd0);
        // forwarded data overrides the register file
        add_row("fwd_add_rs1", r_type(7'h00, 3'h0), PC0, 32'd5, 32'd7,
                forward_sel(1'b1, 1'b0, 32'd100, 32'd0), 3'b010, 32'd107);
        add_row("fwd_add_rs2", r_type(7'h00, 3'h0), PC0, 32'd5, 32'd7,
                forward_sel(1'b0, 1'b1, 32'd0, 32'd16), 3'b010, 32'd21);
        add_row("fwd_beq_t", b_type(13'd16, 3'h0), PC0, 32'd1, 32'd9,
                forward_sel(1'b1, 1'b0, 32'd9, 32'd0), 3'b101, 32'h1010);
        add_row("fwd_beq_n", b_type(13'd16, 3'h0), PC0, 32'd4, 32'd4,
                forward_sel(1'b0, 1'b1, 32'd0, 32'd5), 3'b000, 32'd0);
        add_row("lui", {20'h12345, 5'd1, 7'h37}, PC0, '0, '0, NOF, 3'b010, 32'h12345000);
        add_row("auipc", {20'h80000, 5'd1, 7'h17}, PC0, '0, '0, NOF, 3'b010, 32'h80001000);
        add_row("jal", j_type(21'h00800), PC0, '0, '0, NOF, 3'b101, 32'h1800);
        add_row("jalr", {12'hFFC, 5'd2, 3'h0, 5'd1, 7'h67}, PC0, 32'h20000000, '0, NOF,
                3'b101, 32'h1FFFFFFC);
        add_row("bad_opcode", '1, PC0, 32'd3, 32'd4, NOF, 3'b000, 32'd0);
        add_row("bad_funct7", r_type(7'h01, 3'h0), PC0, 32'd3, 32'd4, NOF, 3'b000, 32'd0);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        wait (table_ready);
        #((rows.size() + 10) * CLK_PERIOD * 4);
        $display("watchdog expired before all table rows were applied");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rstn_i      = 1'b0;
        instr_i     = j_type(21'h00800);    // jump held during reset
        pc_i        = PC0;
        rs1_i       = '0;
        rs2_i       = '0;
        fwd_i       = '0;
        checks      = 0;
        errors      = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (2) begin
            @(posedge clk_i);
            #1;
            check_value("reset", "flush", 1'b1, flush_o);    // combinational even in reset
            check_value("reset", "out_o", '0, out_o);
        end
        rstn_i  = 1'b1;
        instr_i = '0;
        pc_i    = '0;
        @(posedge clk_i);
        #1;
        check_value("reset_exit", "out_o", '0, out_o);

        foreach (rows[i]) begin
            instr_i = rows[i].instr;
            pc_i    = rows[i].pc;
            rs1_i   = rows[i].rs1;
            rs2_i   = rows[i].rs2;
            fwd_i   = rows[i].fwd;
            #2;
            check_value(names[i], "flush", rows[i].exp_ctl[2], flush_o);
            @(posedge clk_i);
            #1;
            check_value(names[i], "reg_write", rows[i].exp_ctl[1], out_o.reg_write);
            check_value(names[i], "jump", rows[i].exp_ctl[0], out_o.jump);
            check_value(names[i], "result", rows[i].exp_result, out_o.result);
            check_value(names[i], "instr", rows[i].instr, out_o.instr);
            check_value(names[i], "pc", rows[i].pc, out_o.pc);
        end

        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- exec_stage.f
verilog/rv_exec_pkg.sv
verilog/exec_decode.sv
verilog/exec_alu.sv
verilog/exec_result.sv
verilog/exec_stage.sv
dv/exec_stage_properties.sv
dv/tb_exec_stage.sv

//--- verilog/exec_alu.sv
module exec_alu (
    input  rv_exec_pkg::alu_req_t req_i,
    output rv_exec_pkg::word_t    result_o,
    output logic                  cond_true_o
);

    logic [rv_exec_pkg::SHAMT_W-1:0] shamt;
    logic                            slt_s;
    logic                            slt_u;
    logic                            br_eq;
    logic                            br_lt_s;
    logic                            br_lt_u;
    logic [rv_exec_pkg::CNT_W-1:0]   clz_cnt;
    logic [rv_exec_pkg::CNT_W-1:0]   ctz_cnt;
    logic [rv_exec_pkg::CNT_W-1:0]   pop_cnt;
    logic                            lead_seen;
    logic                            trail_seen;

    assign shamt = req_i.operand_b[rv_exec_pkg::SHAMT_W-1:0];

    // set-less-than on the datapath operands
    assign slt_s = $signed(req_i.operand_a) < $signed(req_i.operand_b);
    assign slt_u = req_i.operand_a < req_i.operand_b;

    // branch compare on the register operands
    assign br_eq   = req_i.cmp_a == req_i.cmp_b;
    assign br_lt_s = $signed(req_i.cmp_a) < $signed(req_i.cmp_b);
    assign br_lt_u = req_i.cmp_a < req_i.cmp_b;

    always_comb begin
        clz_cnt    = '0;
        ctz_cnt    = '0;
        pop_cnt    = '0;
        lead_seen  = 1'b0;
        trail_seen = 1'b0;
        for (int i = rv_exec_pkg::XLEN - 1; i >= 0; i--) begin
            if (req_i.operand_a[i]) begin
                lead_seen = 1'b1;
            end else if (!lead_seen) begin
                clz_cnt = clz_cnt + 1'b1;
            end
        end
        for (int i = 0; i < rv_exec_pkg::XLEN; i++) begin
            if (req_i.operand_a[i]) begin
                trail_seen = 1'b1;
                pop_cnt    = pop_cnt + 1'b1;
            end else if (!trail_seen) begin
                ctz_cnt = ctz_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (req_i.op)
            rv_exec_pkg::ADD:    result_o = req_i.operand_a + req_i.operand_b;
            rv_exec_pkg::SUB:    result_o = req_i.operand_a - req_i.operand_b;
            rv_exec_pkg::AND:    result_o = req_i.operand_a & req_i.operand_b;
            rv_exec_pkg::OR:     result_o = req_i.operand_a | req_i.operand_b;
            rv_exec_pkg::XOR:    result_o = req_i.operand_a ^ req_i.operand_b;
            rv_exec_pkg::SLL:    result_o = req_i.operand_a << shamt;
            rv_exec_pkg::SRL:    result_o = req_i.operand_a >> shamt;
            rv_exec_pkg::SRA:    result_o = $signed(req_i.operand_a) >>> shamt;
            rv_exec_pkg::SLT:    result_o = {{(rv_exec_pkg::XLEN - 1){1'b0}}, slt_s};
            rv_exec_pkg::SLTU:   result_o = {{(rv_exec_pkg::XLEN - 1){1'b0}}, slt_u};
            rv_exec_pkg::PASS_B: result_o = req_i.operand_b;      // lui
            rv_exec_pkg::CLZ: begin
                result_o = {{(rv_exec_pkg::XLEN - rv_exec_pkg::CNT_W){1'b0}}, clz_cnt};
            end
            rv_exec_pkg::CTZ: begin
                result_o = {{(rv_exec_pkg::XLEN - rv_exec_pkg::CNT_W){1'b0}}, ctz_cnt};
            end
            rv_exec_pkg::CPOP: begin
                result_o = {{(rv_exec_pkg::XLEN - rv_exec_pkg::CNT_W){1'b0}}, pop_cnt};
            end
            default:             result_o = '0;
        endcase
    end

    always_comb begin
        case (req_i.cond)
            rv_exec_pkg::EQ:  cond_true_o = br_eq;
            rv_exec_pkg::NE:  cond_true_o = !br_eq;
            rv_exec_pkg::LT:  cond_true_o = br_lt_s;
            rv_exec_pkg::GE:  cond_true_o = !br_lt_s;
            rv_exec_pkg::LTU: cond_true_o = br_lt_u;
            rv_exec_pkg::GEU: cond_true_o = !br_lt_u;
            default:          cond_true_o = 1'b0;
        endcase
    end

endmodule

//--- verilog/exec_decode.sv
module exec_decode (
    input  rv_exec_pkg::word_t      instr_i,
    input  rv_exec_pkg::word_t      pc_i,
    input  rv_exec_pkg::word_t      rs1_i,
    input  rv_exec_pkg::word_t      rs2_i,
    input  rv_exec_pkg::fwd_t       fwd_i,
    output rv_exec_pkg::alu_req_t   alu_req_o,
    output rv_exec_pkg::exec_ctrl_t ctrl_o
);

    logic [6:0]                     opcode;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic [rv_exec_pkg::REG_AW-1:0] rs2_field;
    rv_exec_pkg::word_t             imm_i;
    rv_exec_pkg::word_t             imm_u;
    rv_exec_pkg::word_t             imm_b;
    rv_exec_pkg::word_t             imm_j;
    rv_exec_pkg::word_t             shamt;
    rv_exec_pkg::word_t             rs1_val;
    rv_exec_pkg::word_t             rs2_val;
    logic                           illegal;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7    = instr_i[31:25];
    assign rs2_field = instr_i[24:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign shamt = {{(rv_exec_pkg::XLEN - rv_exec_pkg::SHAMT_W){1'b0}},
                    instr_i[20 +: rv_exec_pkg::SHAMT_W]};

    // hazard unit picks forwarded data per operand
    assign rs1_val = fwd_i.rs1_sel ? fwd_i.rs1_data : rs1_i;
    assign rs2_val = fwd_i.rs2_sel ? fwd_i.rs2_data : rs2_i;

    always_comb begin
        alu_req_o.op        = rv_exec_pkg::ADD;
        alu_req_o.operand_a = '0;
        alu_req_o.operand_b = '0;
        alu_req_o.cond      = rv_exec_pkg::EQ;
        alu_req_o.cmp_a     = rs1_val;
        alu_req_o.cmp_b     = rs2_val;
        ctrl_o.reg_write    = 1'b0;
        ctrl_o.is_jump      = 1'b0;
        ctrl_o.is_branch    = 1'b0;
        ctrl_o.instr        = instr_i;
        ctrl_o.pc           = pc_i;
        illegal             = 1'b0;

        case (opcode)
            rv_exec_pkg::OPC_LUI: begin
                alu_req_o.op        = rv_exec_pkg::PASS_B;
                alu_req_o.operand_b = imm_u;
                ctrl_o.reg_write    = 1'b1;
            end
            rv_exec_pkg::OPC_AUIPC: begin
                alu_req_o.operand_a = pc_i;
                alu_req_o.operand_b = imm_u;
                ctrl_o.reg_write    = 1'b1;
            end
            rv_exec_pkg::OPC_JAL: begin         // target only, link goes to writeback
                alu_req_o.operand_a = pc_i;
                alu_req_o.operand_b = imm_j;
                ctrl_o.is_jump      = 1'b1;
            end
            rv_exec_pkg::OPC_JALR: begin
                alu_req_o.operand_a = rs1_val;
                alu_req_o.operand_b = imm_i;
                ctrl_o.is_jump      = 1'b1;
                illegal             = (funct3 != 3'b000);
            end
            rv_exec_pkg::OPC_BRANCH: begin
                alu_req_o.operand_a = pc_i;     // adder builds the target
                alu_req_o.operand_b = imm_b;
                ctrl_o.is_branch    = 1'b1;
                case (funct3)
                    rv_exec_pkg::F3_BEQ:  alu_req_o.cond = rv_exec_pkg::EQ;
                    rv_exec_pkg::F3_BNE:  alu_req_o.cond = rv_exec_pkg::NE;
                    rv_exec_pkg::F3_BLT:  alu_req_o.cond = rv_exec_pkg::LT;
                    rv_exec_pkg::F3_BGE:  alu_req_o.cond = rv_exec_pkg::GE;
                    rv_exec_pkg::F3_BLTU: alu_req_o.cond = rv_exec_pkg::LTU;
                    rv_exec_pkg::F3_BGEU: alu_req_o.cond = rv_exec_pkg::GEU;
                    default:              illegal = 1'b1;
                endcase
            end
            rv_exec_pkg::OPC_OP_IMM: begin
                alu_req_o.operand_a = rs1_val;
                alu_req_o.operand_b = imm_i;
                ctrl_o.reg_write    = 1'b1;
                case (funct3)
                    rv_exec_pkg::F3_ADD:  alu_req_o.op = rv_exec_pkg::ADD;
                    rv_exec_pkg::F3_SLT:  alu_req_o.op = rv_exec_pkg::SLT;
                    rv_exec_pkg::F3_SLTU: alu_req_o.op = rv_exec_pkg::SLTU;
                    rv_exec_pkg::F3_XOR:  alu_req_o.op = rv_exec_pkg::XOR;
                    rv_exec_pkg::F3_OR:   alu_req_o.op = rv_exec_pkg::OR;
                    rv_exec_pkg::F3_AND:  alu_req_o.op = rv_exec_pkg::AND;
                    rv_exec_pkg::F3_SLL: begin
                        alu_req_o.operand_b = shamt;
                        if (funct7 == rv_exec_pkg::F7_BASE) begin
                            alu_req_o.op = rv_exec_pkg::SLL;
                        end else if (funct7 == rv_exec_pkg::F7_COUNT) begin
                            case (rs2_field)            // counts look at operand_a only
                                rv_exec_pkg::CNT_CLZ:  alu_req_o.op = rv_exec_pkg::CLZ;
                                rv_exec_pkg::CNT_CTZ:  alu_req_o.op = rv_exec_pkg::CTZ;
                                rv_exec_pkg::CNT_CPOP: alu_req_o.op = rv_exec_pkg::CPOP;
                                default:               illegal = 1'b1;
                            endcase
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    default: begin                      // srli / srai
                        alu_req_o.operand_b = shamt;
                        if (funct7 == rv_exec_pkg::F7_BASE) begin
                            alu_req_o.op = rv_exec_pkg::SRL;
                        end else if (funct7 == rv_exec_pkg::F7_ALT) begin
                            alu_req_o.op = rv_exec_pkg::SRA;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                endcase
            end
            rv_exec_pkg::OPC_OP: begin
                alu_req_o.operand_a = rs1_val;
                alu_req_o.operand_b = rs2_val;
                ctrl_o.reg_write    = 1'b1;
                if (funct7 == rv_exec_pkg::F7_BASE) begin
                    case (funct3)
                        rv_exec_pkg::F3_ADD:  alu_req_o.op = rv_exec_pkg::ADD;
                        rv_exec_pkg::F3_SLL:  alu_req_o.op = rv_exec_pkg::SLL;
                        rv_exec_pkg::F3_SLT:  alu_req_o.op = rv_exec_pkg::SLT;
                        rv_exec_pkg::F3_SLTU: alu_req_o.op = rv_exec_pkg::SLTU;
                        rv_exec_pkg::F3_XOR:  alu_req_o.op = rv_exec_pkg::XOR;
                        rv_exec_pkg::F3_SR:   alu_req_o.op = rv_exec_pkg::SRL;
                        rv_exec_pkg::F3_OR:   alu_req_o.op = rv_exec_pkg::OR;
                        default:              alu_req_o.op = rv_exec_pkg::AND;
                    endcase
                end else if (funct7 == rv_exec_pkg::F7_ALT && funct3 == rv_exec_pkg::F3_ADD) begin
                    alu_req_o.op = rv_exec_pkg::SUB;
                end else if (funct7 == rv_exec_pkg::F7_ALT && funct3 == rv_exec_pkg::F3_SR) begin
                    alu_req_o.op = rv_exec_pkg::SRA;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase

        // anything not decoded becomes a bubble with a zero result
        if (illegal) begin
            alu_req_o.op        = rv_exec_pkg::ADD;
            alu_req_o.operand_a = '0;
            alu_req_o.operand_b = '0;
            ctrl_o.reg_write    = 1'b0;
            ctrl_o.is_jump      = 1'b0;
            ctrl_o.is_branch    = 1'b0;
        end
    end

endmodule

//--- verilog/exec_result.sv
module exec_result (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  rv_exec_pkg::exec_ctrl_t ctrl_i,
    input  rv_exec_pkg::word_t      result_i,
    input  logic                    cond_true_i,
    output logic                    flush_o,
    output rv_exec_pkg::exec_out_t  out_o
);

    logic               taken;
    logic               br_not_taken;
    rv_exec_pkg::word_t result_d;

    assign taken        = ctrl_i.is_jump || (ctrl_i.is_branch && cond_true_i);
    assign br_not_taken = ctrl_i.is_branch && !cond_true_i;

    // combinational, so fetch sees it one cycle before out_o.jump
    assign flush_o = taken;

    // a fall-through branch carries no target
    assign result_d = br_not_taken ? '0 : result_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            out_o <= '0;
        end else begin
            out_o.reg_write <= ctrl_i.reg_write;
            out_o.jump      <= taken;
            out_o.result    <= result_d;
            out_o.instr     <= ctrl_i.instr;
            out_o.pc        <= ctrl_i.pc;
        end
    end

endmodule

//--- verilog/exec_stage.sv
module exec_stage (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  rv_exec_pkg::word_t     instr_i,
    input  rv_exec_pkg::word_t     pc_i,
    input  rv_exec_pkg::word_t     rs1_i,
    input  rv_exec_pkg::word_t     rs2_i,
    input  rv_exec_pkg::fwd_t      fwd_i,
    output logic                   flush_o,
    output rv_exec_pkg::exec_out_t out_o
);

    rv_exec_pkg::alu_req_t   alu_req;
    rv_exec_pkg::exec_ctrl_t ctrl;
    rv_exec_pkg::word_t      alu_result;
    logic                    cond_true;

    exec_decode u_decode (
        .instr_i   (instr_i),
        .pc_i      (pc_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .fwd_i     (fwd_i),
        .alu_req_o (alu_req),
        .ctrl_o    (ctrl)
    );

    exec_alu u_alu (
        .req_i       (alu_req),
        .result_o    (alu_result),
        .cond_true_o (cond_true)
    );

    // registers toward the memory stage
    exec_result u_result (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .ctrl_i      (ctrl),
        .result_i    (alu_result),
        .cond_true_i (cond_true),
        .flush_o     (flush_o),
        .out_o       (out_o)
    );

endmodule

//--- verilog/rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;                     // register index width
    localparam int SHAMT_W = 5;
    localparam int CNT_W   = $clog2(XLEN + 1);      // bit-count result, 0..32

    // major opcodes kept by the stage
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [6:0] F7_BASE  = 7'b0000000;
    localparam logic [6:0] F7_ALT   = 7'b0100000;   // sub / arithmetic shift
    localparam logic [6:0] F7_COUNT = 7'b0110000;   // clz, ctz, cpop

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // op / op-imm funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;        // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // rs2 field picks the count instruction
    localparam logic [REG_AW-1:0] CNT_CLZ  = 5'b00000;
    localparam logic [REG_AW-1:0] CNT_CTZ  = 5'b00001;
    localparam logic [REG_AW-1:0] CNT_CPOP = 5'b00010;

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA,
        SLT, SLTU, PASS_B, CLZ, CTZ, CPOP
    } alu_op_e;

    typedef enum logic [2:0] {
        EQ, NE, LT, GE, LTU, GEU
    } cmp_e;

    typedef struct packed {
        logic  rs1_sel;
        logic  rs2_sel;
        word_t rs1_data;
        word_t rs2_data;
    } fwd_t;

    // cmp_a and cmp_b feed the branch comparator, the adder keeps operand_a/b
    typedef struct packed {
        alu_op_e op;
        word_t   operand_a;
        word_t   operand_b;
        cmp_e    cond;
        word_t   cmp_a;
        word_t   cmp_b;
    } alu_req_t;

    typedef struct packed {
        logic  reg_write;
        logic  is_jump;
        logic  is_branch;
        word_t instr;
        word_t pc;
    } exec_ctrl_t;

    typedef struct packed {
        logic  reg_write;
        logic  jump;
        word_t result;
        word_t instr;
        word_t pc;
    } exec_out_t;

endpackage
